//--- tb.f
rtl/camera_pkg.sv
rtl/ps2_key_decoder.sv
rtl/camera_controller.sv
rtl/camera_rotator.sv
rtl/camera_datapath.sv
rtl/camera_top.sv
verification/tb_camera_top.sv

//--- Makefile
# Verilator build and run of the camera control testbench

VERILATOR ?= verilator
TOP ?= tb_camera_top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
FAIL_MSG ?= Checks failed
PASS_MSG ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED, run did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_camera_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_camera_top;
	import camera_pkg::*;

	localparam int STEP_SHIFT = 4;
	localparam int TIMEOUT = 200;
	localparam int HS_TIMEOUT = 10;
	localparam int NUM_ROWS = 22;

	localparam vector_t UNIT_X = {FP_ONE, FP_ZERO, FP_ZERO};
	localparam vector_t UNIT_Y = {FP_ZERO, FP_ONE, FP_ZERO};
	localparam vector_t UNIT_Z = {FP_ZERO, FP_ZERO, FP_ONE};

	// break prefix, key code, key pressed mid-run (0 for none), frames expected
	typedef struct packed {
		logic brk;
		scan_code_t code;
		scan_code_t extra;
		int frames;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	scan_code_t scan_code;
	logic scan_req;
	logic rendering_done;
	logic scan_ack;
	logic render_frame;
	vector_t E;
	vector_t U;
	vector_t V;
	vector_t W;

	row_t rows [NUM_ROWS];
	// reference basis in U V W order
	vector_t ref_basis [3];
	vector_t ref_e;
	logic ref_parity;
	logic [2:0] ref_pair;
	int seed = 32'hfedc34bd;
	int frames_seen = 0;
	int dones_given = 0;
	int done_grant = 0;
	logic rend_busy = 1'b0;

	camera_top #(
		.STEP_SHIFT (STEP_SHIFT)
	) u_dut (
		.clk            (clk),
		.rst            (rst),
		.scan_code      (scan_code),
		.scan_req       (scan_req),
		.rendering_done (rendering_done),
		.scan_ack       (scan_ack),
		.render_frame   (render_frame),
		.E              (E),
		.U              (U),
		.V              (V),
		.W              (W)
	);

	always #4 clk = ~clk;

	// counts every pulse even while the renderer is busy
	always @(posedge clk) begin
		if (render_frame === 1'b1) begin
			frames_seen++;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopping at first error");
	endtask

	// wait until 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_vector(input string name, input vector_t got, input vector_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic verify_camera();
		check_vector("U", U, ref_basis[0]);
		check_vector("V", V, ref_basis[1]);
		check_vector("W", W, ref_basis[2]);
		check_coord("E.x", E[95:64], ref_e[95:64]);
		check_coord("E.y", E[63:32], ref_e[63:32]);
		check_coord("E.z", E[31:0], ref_e[31:0]);
	endtask

	function automatic vector_t negate_vec(vector_t v);
		vector_t r;
		coord_t c;
		for (int i = 0; i < 3; i++) begin
			c = v[95 - 32*i -: 32];
			r[95 - 32*i -: 32] = -c;
		end
		return r;
	endfunction

	function automatic int key_of_code(scan_code_t code);
		case (code)
			SC_D: return 0;
			SC_A: return 1;
			SC_E: return 2;
			SC_Q: return 3;
			SC_W: return 4;
			SC_S: return 5;
			SC_L: return 6;
			SC_J: return 7;
			SC_O: return 8;
			SC_U: return 9;
			SC_I: return 10;
			SC_K: return 11;
			default: return 12;
		endcase
	endfunction

	// one step of 1/16 along the signed axis
	// d q and s step against their axis
	task automatic apply_step(input int idx);
		vector_t ax;
		coord_t step;
		coord_t cur;
		ax = ref_basis[idx / 2];
		for (int i = 0; i < 3; i++) begin
			step = ax[95 - 32*i -: 32];
			step = step >>> STEP_SHIFT;
			cur = ref_e[95 - 32*i -: 32];
			if (idx == 0 || idx == 3 || idx == 5) begin
				cur = cur - step;
			end else begin
				cur = cur + step;
			end
			ref_e[95 - 32*i -: 32] = cur;
		end
	endtask

	// 90 degree turn with the parity lock
	task automatic apply_rotation(input int idx);
		logic [2:0] pair;
		int a;
		int b;
		int c;
		vector_t vb;
		vector_t vc;
		pair = 3'(idx / 2);
		if (!ref_parity || pair == ref_pair) begin
			case (pair)
				3'd3: a = 1;
				3'd4: a = 0;
				default: a = 2;
			endcase
			b = (a + 1) % 3;
			c = (a + 2) % 3;
			vb = ref_basis[b];
			vc = ref_basis[c];
			if (idx % 2 == 0) begin
				ref_basis[b] = vc;
				ref_basis[c] = negate_vec(vb);
			end else begin
				ref_basis[b] = negate_vec(vc);
				ref_basis[c] = vb;
			end
			ref_parity = !ref_parity;
			ref_pair = pair;
		end
	endtask

	// four-phase handshake on the scan-code input
	task automatic send_code(input scan_code_t code);
		int t;
		scan_code = code;
		scan_req = 1'b1;
		t = 0;
		while (scan_ack !== 1'b1) begin
			tick();
			t++;
			if (t > HS_TIMEOUT) begin
				abort_run($sformatf("scan_ack never rose for scan code %h", code));
			end
		end
		scan_req = 1'b0;
		t = 0;
		while (scan_ack !== 1'b0) begin
			tick();
			t++;
			if (t > HS_TIMEOUT) begin
				abort_run($sformatf("scan_ack never fell for scan code %h", code));
			end
		end
	endtask

	task automatic await_frames(input int target);
		int t;
		t = 0;
		while (frames_seen < target) begin
			tick();
			t++;
			if (t > TIMEOUT) begin
				abort_run("render_frame did not arrive in time");
			end
		end
	endtask

	task automatic await_idle();
		int t;
		t = 0;
		while (rend_busy) begin
			tick();
			t++;
			if (t > TIMEOUT) begin
				abort_run("renderer did not finish its frame in time");
			end
		end
	endtask

	// renderer answers each frame after 2 to 9 cycles once a done is granted
	initial begin : renderer
		int delay;
		int t;
		rendering_done = 1'b0;
		tick();
		forever begin
			if (render_frame === 1'b1) begin
				rend_busy = 1'b1;
				delay = 2 + (($random(seed) & 32'h7fff_ffff) % 8);
				repeat (delay - 1) tick();
				t = 0;
				while (dones_given >= done_grant) begin
					tick();
					t++;
					if (t > TIMEOUT) begin
						abort_run("renderer held a frame that was never released");
					end
				end
				rendering_done = 1'b1;
				dones_given++;
				tick();
				rendering_done = 1'b0;
				rend_busy = 1'b0;
			end else begin
				tick();
			end
		end
	end

	initial begin : main
		int start;
		int idx;
		int quiet;
		logic is_move;
		logic is_rot;
		rst = 1'b1;
		scan_code = '0;
		scan_req = 1'b0;
		ref_basis[0] = UNIT_X;
		ref_basis[1] = UNIT_Y;
		ref_basis[2] = UNIT_Z;
		ref_e = '0;
		ref_parity = 1'b0;
		ref_pair = 3'd0;

		// unknown code and then a break prefix with an unknown code
		rows[0] = '{1'b0, 8'h5A, 8'h00, 0};
		rows[1] = '{1'b1, 8'h5A, 8'h00, 0};
		rows[2] = '{1'b0, SC_D, 8'h00, 2};
		rows[3] = '{1'b0, SC_A, 8'h00, 3};
		rows[4] = '{1'b0, SC_E, 8'h00, 1};
		rows[5] = '{1'b0, SC_Q, 8'h00, 2};
		rows[6] = '{1'b0, SC_W, 8'h00, 3};
		rows[7] = '{1'b0, SC_S, 8'h00, 1};
		rows[8] = '{1'b0, SC_L, 8'h00, 1};
		rows[9] = '{1'b0, SC_L, 8'h00, 1};
		rows[10] = '{1'b0, SC_L, 8'h00, 1};
		rows[11] = '{1'b0, SC_L, 8'h00, 1};
		// one turn about U locks out V until U turns again
		rows[12] = '{1'b0, SC_O, 8'h00, 1};
		rows[13] = '{1'b0, SC_L, 8'h00, 0};
		rows[14] = '{1'b0, SC_U, 8'h00, 1};
		rows[15] = '{1'b0, SC_I, 8'h00, 1};
		rows[16] = '{1'b0, SC_K, 8'h00, 1};
		rows[17] = '{1'b0, SC_J, 8'h00, 1};
		rows[18] = '{1'b0, SC_J, 8'h00, 1};
		rows[19] = '{1'b0, SC_O, 8'h00, 1};
		// moves along the rotated basis with a stray press mid-run
		rows[20] = '{1'b0, SC_W, SC_I, 2};
		rows[21] = '{1'b0, SC_D, SC_A, 1};

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// nothing moves before the first request
		quiet = 0;
		repeat (8) begin
			tick();
			if (scan_ack) begin
				quiet++;
			end
		end
		check_count("scan_ack high cycles", quiet, 0);
		check_count("render_frame pulses", frames_seen, 0);
		verify_camera();

		for (int r = 0; r < NUM_ROWS; r++) begin
			start = frames_seen;
			idx = key_of_code(rows[r].code);
			is_move = !rows[r].brk && idx <= 5;
			is_rot = !rows[r].brk && idx >= 6 && idx <= 11;
			// last frame of a run stays open until the release is in
			done_grant += is_move ? rows[r].frames - 1 : rows[r].frames;
			if (rows[r].brk) begin
				send_code(SC_BREAK);
			end
			send_code(rows[r].code);
			if (is_move) begin
				await_frames(start + rows[r].frames);
				if (rows[r].extra != 8'h00) begin
					send_code(rows[r].extra);
					send_code(SC_BREAK);
					send_code(rows[r].extra);
				end
				send_code(SC_BREAK);
				send_code(rows[r].code);
				done_grant += 1;
				await_idle();
				repeat (rows[r].frames) apply_step(idx);
			end else if (rows[r].frames > 0) begin
				await_frames(start + rows[r].frames);
				await_idle();
			end else begin
				// outputs would change within four cycles
				repeat (6) tick();
			end
			if (is_rot) begin
				apply_rotation(idx);
				send_code(SC_BREAK);
				send_code(rows[r].code);
			end
			check_count("render_frame pulses", frames_seen - start, rows[r].frames);
			verify_camera();
			if (r == 11) begin
				check_vector("U after four turns", U, UNIT_X);
				check_vector("V after four turns", V, UNIT_Y);
				check_vector("W after four turns", W, UNIT_Z);
			end
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/camera_top.sv
`timescale 1ns/1ps
`default_nettype none

module camera_top #(
	parameter int STEP_SHIFT = 4
) (
	input  logic clk,
	input  logic rst,
	input  camera_pkg::scan_code_t scan_code,
	input  logic scan_req,
	input  logic rendering_done,
	output logic scan_ack,
	output logic render_frame,
	output camera_pkg::vector_t E,
	output camera_pkg::vector_t U,
	output camera_pkg::vector_t V,
	output camera_pkg::vector_t W
);
	import camera_pkg::*;

	key_bits_t key_press;
	key_bits_t key_release;
	key_idx_t active_key;
	vector_t U_n;
	vector_t V_n;
	vector_t W_n;
	logic step_en;

	ps2_key_decoder u_decoder (
		.clk         (clk),
		.rst         (rst),
		.scan_code   (scan_code),
		.scan_req    (scan_req),
		.scan_ack    (scan_ack),
		.key_press   (key_press),
		.key_release (key_release)
	);

	camera_controller u_controller (
		.clk            (clk),
		.rst            (rst),
		.key_press      (key_press),
		.key_release    (key_release),
		.rendering_done (rendering_done),
		.U_n            (U_n),
		.V_n            (V_n),
		.W_n            (W_n),
		.render_frame   (render_frame),
		.step_en        (step_en),
		.active_key     (active_key),
		.U              (U),
		.V              (V),
		.W              (W)
	);

	camera_rotator u_rotator (
		.rot_key (active_key),
		.U       (U),
		.V       (V),
		.W       (W),
		.U_n     (U_n),
		.V_n     (V_n),
		.W_n     (W_n)
	);

	camera_datapath #(
		.STEP_SHIFT (STEP_SHIFT)
	) u_datapath (
		.clk      (clk),
		.rst      (rst),
		.step_en  (step_en),
		.move_key (active_key),
		.U        (U),
		.V        (V),
		.W        (W),
		.E        (E)
	);

endmodule

`default_nettype wire

//--- rtl/camera_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module camera_datapath #(
	parameter int STEP_SHIFT = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic step_en,
	input  camera_pkg::key_idx_t move_key,
	input  camera_pkg::vector_t U,
	input  camera_pkg::vector_t V,
	input  camera_pkg::vector_t W,
	output camera_pkg::vector_t E
);
	import camera_pkg::*;

	vector_t axis;
	vector_t e_next;
	logic neg;

	// rotation keys select no axis so E holds
	always_comb begin
		case (move_key[3:1])
			KEY_D[3:1]: axis = U;
			KEY_E[3:1]: axis = V;
			KEY_W[3:1]: axis = W;
			default: axis = '0;
		endcase
	end

	// d is -U at the even index, while e and w are positive there
	assign neg = move_key[0] ^ (move_key[3:1] == KEY_D[3:1]);

	always_comb begin
		coord_t step;
		coord_t cur;
		e_next = E;
		for (int i = 0; i < 3; i++) begin
			step = vec_coord(axis, i) >>> STEP_SHIFT;
			cur = vec_coord(E, i);
			e_next[95 - 32*i -: 32] = neg ? cur - step : cur + step;
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			E <= vec_make(FP_ZERO, FP_ZERO, FP_ZERO);
		end else if (step_en) begin
			E <= e_next;
		end
	end

endmodule

`default_nettype wire

//--- rtl/camera_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module camera_rotator (
	input  camera_pkg::key_idx_t rot_key,
	input  camera_pkg::vector_t U,
	input  camera_pkg::vector_t V,
	input  camera_pkg::vector_t W,
	output camera_pkg::vector_t U_n,
	output camera_pkg::vector_t V_n,
	output camera_pkg::vector_t W_n
);
	import camera_pkg::*;

	localparam logic [2:0] PAIR_ROT_V = KEY_L[3:1];
	localparam logic [2:0] PAIR_ROT_U = KEY_O[3:1];
	localparam logic [2:0] PAIR_ROT_W = KEY_I[3:1];

	vector_t b;
	vector_t c;
	vector_t b_n;
	vector_t c_n;
	logic pos;

	// even index within a rotation pair turns positive
	assign pos = !rot_key[0];

	// (B,C) is the pair following the rotation axis in U,V,W order
	always_comb begin
		case (rot_key[3:1])
			PAIR_ROT_U: begin
				b = V;
				c = W;
			end
			PAIR_ROT_V: begin
				b = W;
				c = U;
			end
			default: begin
				b = U;
				c = V;
			end
		endcase
	end

	assign b_n = pos ? c : vec_neg(c);
	assign c_n = pos ? vec_neg(b) : b;

	always_comb begin
		U_n = U;
		V_n = V;
		W_n = W;
		case (rot_key[3:1])
			PAIR_ROT_U: begin
				V_n = b_n;
				W_n = c_n;
			end
			PAIR_ROT_V: begin
				W_n = b_n;
				U_n = c_n;
			end
			PAIR_ROT_W: begin
				U_n = b_n;
				V_n = c_n;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/camera_controller.sv
`timescale 1ns/1ps
`default_nettype none

module camera_controller (
	input  logic clk,
	input  logic rst,
	input  camera_pkg::key_bits_t key_press,
	input  camera_pkg::key_bits_t key_release,
	input  logic rendering_done,
	input  camera_pkg::vector_t U_n,
	input  camera_pkg::vector_t V_n,
	input  camera_pkg::vector_t W_n,
	output logic render_frame,
	output logic step_en,
	output camera_pkg::key_idx_t active_key,
	output camera_pkg::vector_t U,
	output camera_pkg::vector_t V,
	output camera_pkg::vector_t W
);
	import camera_pkg::*;

	ctrl_state_t state;
	key_idx_t press_idx;
	logic is_rot;
	logic is_move;
	logic held;
	logic rot_parity;
	logic [2:0] last_pair;
	logic frame_busy;
	logic rot_ok;
	logic rel_hit;
	logic can_start;
	logic accept_rot;
	logic accept_move;
	logic next_frame;
	logic stop_run;

	// one pressed key gives its index, none or several give KEY_NONE
	always_comb begin
		int hits;
		hits = 0;
		press_idx = KEY_NONE;
		for (int i = 0; i < NUM_KEYS; i++) begin
			if (key_press[i]) begin
				hits = hits + 1;
				press_idx = key_idx_t'(i);
			end
		end
		if (hits != 1) begin
			press_idx = KEY_NONE;
		end
	end

	assign is_move = (press_idx <= KEY_S);
	assign is_rot = (press_idx >= KEY_L) && (press_idx <= KEY_K);

	// second rotation of a pair must stay on the same axis
	assign rot_ok = !rot_parity || (press_idx[3:1] == last_pair);

	// only the release of the held key ends the run
	assign rel_hit = (key_release & (key_bits_t'(1) << active_key)) != '0;

	assign can_start = (state == IDLE) && !frame_busy;
	assign accept_rot = can_start && is_rot && rot_ok;
	assign accept_move = can_start && is_move;
	assign stop_run = (state == RENDERING) && rel_hit;
	assign next_frame = (state == RENDERING) && held && rendering_done && !rel_hit;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= IDLE;
			render_frame <= 1'b0;
			step_en <= 1'b0;
			active_key <= KEY_NONE;
			held <= 1'b0;
			rot_parity <= 1'b0;
			last_pair <= 3'd0;
			frame_busy <= 1'b0;
		end else begin
			render_frame <= accept_rot || accept_move || next_frame;
			step_en <= accept_move || next_frame;

			if (accept_rot || accept_move) begin
				active_key <= press_idx;
			end

			if (accept_rot) begin
				rot_parity <= ~rot_parity;
				last_pair <= press_idx[3:1];
			end

			if (accept_move) begin
				held <= 1'b1;
			end else if (stop_run) begin
				held <= 1'b0;
			end

			// one frame in flight at most
			if (accept_rot || accept_move || next_frame) begin
				frame_busy <= 1'b1;
			end else if (rendering_done) begin
				frame_busy <= 1'b0;
			end

			case (state)
				IDLE: begin
					if (accept_rot) begin
						state <= ROTATING;
					end else if (accept_move) begin
						state <= RENDERING;
					end
				end
				ROTATING: state <= IDLE;
				RENDERING: begin
					if (stop_run) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// basis starts as the unit axes
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			U <= vec_make(FP_ONE, FP_ZERO, FP_ZERO);
			V <= vec_make(FP_ZERO, FP_ONE, FP_ZERO);
			W <= vec_make(FP_ZERO, FP_ZERO, FP_ONE);
		end else if (state == ROTATING) begin
			U <= U_n;
			V <= V_n;
			W <= W_n;
		end
	end

endmodule

`default_nettype wire

//--- rtl/ps2_key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  logic clk,
	input  logic rst,
	input  camera_pkg::scan_code_t scan_code,
	input  logic scan_req,
	output logic scan_ack,
	output camera_pkg::key_bits_t key_press,
	output camera_pkg::key_bits_t key_release
);
	import camera_pkg::*;

	typedef enum logic {WAIT_REQ, ACK_HIGH} hs_state_t;

	hs_state_t hs_state;
	scan_code_t code_q;
	logic code_vld;
	logic brk_pending;
	key_bits_t code_bits;

	// one bit per known make code, zero for anything else
	function automatic key_bits_t code_to_bits(scan_code_t code);
		key_bits_t bits;
		bits = '0;
		case (code)
			SC_D: bits[KEY_D] = 1'b1;
			SC_A: bits[KEY_A] = 1'b1;
			SC_E: bits[KEY_E] = 1'b1;
			SC_Q: bits[KEY_Q] = 1'b1;
			SC_W: bits[KEY_W] = 1'b1;
			SC_S: bits[KEY_S] = 1'b1;
			SC_L: bits[KEY_L] = 1'b1;
			SC_J: bits[KEY_J] = 1'b1;
			SC_O: bits[KEY_O] = 1'b1;
			SC_U: bits[KEY_U] = 1'b1;
			SC_I: bits[KEY_I] = 1'b1;
			SC_K: bits[KEY_K] = 1'b1;
			default: bits = '0;
		endcase
		return bits;
	endfunction

	assign scan_ack = (hs_state == ACK_HIGH);
	assign code_bits = code_to_bits(code_q);

	// four-phase intake, ack follows req by one edge in both directions
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			hs_state <= WAIT_REQ;
			code_vld <= 1'b0;
		end else begin
			code_vld <= 1'b0;
			case (hs_state)
				WAIT_REQ: begin
					if (scan_req) begin
						hs_state <= ACK_HIGH;
						code_vld <= 1'b1;
					end
				end
				ACK_HIGH: begin
					if (!scan_req) begin
						hs_state <= WAIT_REQ;
					end
				end
				default: hs_state <= WAIT_REQ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hs_state == WAIT_REQ && scan_req) begin
			code_q <= scan_code;
		end
	end

	// make/break tracking and single-cycle key pulses
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			brk_pending <= 1'b0;
			key_press <= '0;
			key_release <= '0;
		end else begin
			key_press <= '0;
			key_release <= '0;
			if (code_vld) begin
				if (code_q == SC_BREAK) begin
					brk_pending <= 1'b1;
				end else begin
					// unknown codes give zero bits but still drop the prefix
					brk_pending <= 1'b0;
					if (brk_pending) begin
						key_release <= code_bits;
					end else begin
						key_press <= code_bits;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/camera_pkg.sv
`default_nettype none

package camera_pkg;

	// signed fixed point, 16 fractional bits
	localparam int FRAC_BITS = 16;

	typedef logic signed [31:0] coord_t;

	// x in [95:64], y in [63:32], z in [31:0]
	typedef logic [95:0] vector_t;

	localparam coord_t FP_ONE = coord_t'(32'sd1 <<< FRAC_BITS);
	localparam coord_t FP_ZERO = coord_t'(0);

	localparam int NUM_KEYS = 12;

	typedef logic [3:0] key_idx_t;
	typedef logic [NUM_KEYS-1:0] key_bits_t;

	// bits 3:1 select the pair, bit 0 the direction
	localparam key_idx_t KEY_D = 4'd0;
	localparam key_idx_t KEY_A = 4'd1;
	localparam key_idx_t KEY_E = 4'd2;
	localparam key_idx_t KEY_Q = 4'd3;
	localparam key_idx_t KEY_W = 4'd4;
	localparam key_idx_t KEY_S = 4'd5;
	localparam key_idx_t KEY_L = 4'd6;
	localparam key_idx_t KEY_J = 4'd7;
	localparam key_idx_t KEY_O = 4'd8;
	localparam key_idx_t KEY_U = 4'd9;
	localparam key_idx_t KEY_I = 4'd10;
	localparam key_idx_t KEY_K = 4'd11;
	localparam key_idx_t KEY_NONE = 4'd12;

	typedef logic [7:0] scan_code_t;

	// PS/2 set-2 make codes
	localparam scan_code_t SC_D = 8'h23;
	localparam scan_code_t SC_A = 8'h1C;
	localparam scan_code_t SC_E = 8'h24;
	localparam scan_code_t SC_Q = 8'h15;
	localparam scan_code_t SC_W = 8'h1D;
	localparam scan_code_t SC_S = 8'h1B;
	localparam scan_code_t SC_L = 8'h4B;
	localparam scan_code_t SC_J = 8'h3B;
	localparam scan_code_t SC_O = 8'h44;
	localparam scan_code_t SC_U = 8'h3C;
	localparam scan_code_t SC_I = 8'h43;
	localparam scan_code_t SC_K = 8'h42;
	localparam scan_code_t SC_BREAK = 8'hF0;

	typedef enum logic [1:0] {IDLE, ROTATING, RENDERING} ctrl_state_t;

	function automatic vector_t vec_make(coord_t x, coord_t y, coord_t z);
		return {x, y, z};
	endfunction

	// componentwise negation
	function automatic vector_t vec_neg(vector_t v);
		return {-coord_t'(v[95:64]), -coord_t'(v[63:32]), -coord_t'(v[31:0])};
	endfunction

	// component 0 is x, 2 is z
	function automatic coord_t vec_coord(vector_t v, int idx);
		return coord_t'(v[95 - 32*idx -: 32]);
	endfunction

endpackage

`default_nettype wire
